//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu_on_board \
    -f vlog.f \
    -Mdir obj_dir

sim_output=$(./obj_dir/Vtb_cpu_on_board)
echo "$sim_output"

# Pass only when the testbench printed its pass line
if grep -qx "Everything OK" <<< "$sim_output"; then
    exit 0
fi
exit 1

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // Reset low for the first 5 rising edges
    initial begin
        KEY0 = 1'b0;
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

//--- test/tb_cpu_on_board.sv
`timescale 1ns/10ps
`include "soc_config.svh"

module tb_cpu_on_board import soc_pkg::*; ();

    // Enable cycle to done cycle
    localparam int DONE_LATENCY = 3;
    localparam int WAIT_LIMIT   = 20;
    localparam int RANDOM_OPS   = 40;

    logic       CLOCK_50;
    logic       KEY0;
    cpu_req_t   cpu_req;
    cpu_rsp_t   cpu_rsp;
    logic       key_valid;
    logic [7:0] key_ascii;
    logic       interrupt_ack;
    logic [3:0] interrupt_vector;

    int     error_count;
    int     timeout_count;
    integer seed;

    // Reference RAM, keyed by CPU byte address
    logic [31:0] ref_mem [bit [63:0]];

    logic done_any;
    logic done_prev;

    tb_clock u_clock (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    cpu_on_board u_dut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .cpu_req          (cpu_req),
        .cpu_rsp          (cpu_rsp),
        .key_valid        (key_valid),
        .key_ascii        (key_ascii),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector)
    );

    assign done_any = cpu_rsp.read_done || cpu_rsp.write_done;

    task automatic report_error(input string msg);
        error_count++;
        $display("[ERROR] %0d ns: %s", $time, msg);
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        assert (got === exp) else begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    // Byte address of a word inside a bank
    function automatic logic [63:0] ram_addr(input int bank, input int word);
        return 64'(`RAM_BASE) + 64'(bank * `BANK_BYTES + word * 4);
    endfunction

    // Output checks on every falling edge
    always @(negedge CLOCK_50) begin
        if (!KEY0) begin
            assert (!done_any && !cpu_rsp.error && interrupt_vector == 4'd0) else begin
                report_error("done, error or interrupt high during reset");
            end
        end else begin
            assert (!(cpu_rsp.read_done && cpu_rsp.write_done)) else begin
                report_error("read_done and write_done high together");
            end
            assert (!cpu_rsp.error || done_any) else begin
                report_error("error raised without a done pulse");
            end
            // Done is a one-cycle pulse
            assert (!(done_prev && done_any)) else begin
                report_error("done held for more than one cycle");
            end
            assert (interrupt_vector <= 4'd1) else begin
                report_error("interrupt_vector outside 0 and 1");
            end
        end
        done_prev <= done_any;
    end

    // One CPU request, held until done, then the enable drops
    task automatic run_access(input logic is_write, input logic [63:0] addr,
                              input logic [63:0] wdata, output logic [63:0] rdata,
                              output logic err);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        rdata  = '0;
        err    = 1'b0;
        @(posedge CLOCK_50);
        cpu_req.address      <= addr;
        cpu_req.write_data   <= wdata;
        cpu_req.read_enable  <= !is_write;
        cpu_req.write_enable <= is_write;
        // First falling edge lies in the enable cycle
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge CLOCK_50);
            if (done_any) begin
                seen = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!seen) begin
            timeout_count++;
            $display("Timeout: no done pulse within %0d cycles for the access at address %h",
                     WAIT_LIMIT, addr);
        end else begin
            assert (cycles == DONE_LATENCY) else begin
                report_error($sformatf("done after %0d cycles at %h", cycles, addr));
            end
            assert (cpu_rsp.write_done == is_write) else begin
                report_error($sformatf("wrong done kind at %h", addr));
            end
            rdata = cpu_rsp.read_data;
            err   = cpu_rsp.error;
        end
        @(posedge CLOCK_50);
        cpu_req.read_enable  <= 1'b0;
        cpu_req.write_enable <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    task automatic write_ram(input logic [63:0] addr, input logic [63:0] data);
        logic [63:0] rdata;
        logic        err;
        run_access(1'b1, addr, data, rdata, err);
        assert (!err) else report_error($sformatf("error on RAM write at %h", addr));
        // Only the low half reaches the 32-bit RAM
        ref_mem[addr] = data[31:0];
    endtask

    task automatic read_expect(input logic [63:0] addr, input logic [63:0] exp);
        logic [63:0] rdata;
        logic        err;
        run_access(1'b0, addr, '0, rdata, err);
        assert (!err) else report_error($sformatf("error on read at %h", addr));
        check_value(rdata, exp, $sformatf("read at %h", addr));
    endtask

    task automatic check_all_ram();
        foreach (ref_mem[a]) begin
            read_expect(a, {32'd0, ref_mem[a]});
        end
    endtask

    // Unmapped access, write then read, both flagged
    task automatic access_unmapped(input logic [63:0] addr);
        logic [63:0] rdata;
        logic        err;
        run_access(1'b1, addr, {$random(seed), $random(seed)}, rdata, err);
        assert (err) else report_error($sformatf("no error on write at %h", addr));
        run_access(1'b0, addr, '0, rdata, err);
        assert (err) else report_error($sformatf("no error on read at %h", addr));
        check_value(rdata, 64'd0, $sformatf("unmapped read at %h", addr));
    endtask

    // Drive the key inputs for one cycle
    task automatic strobe_key_inputs(input logic valid, input logic [7:0] code,
                                     input logic ack);
        @(posedge CLOCK_50);
        key_valid     <= valid;
        key_ascii     <= code;
        interrupt_ack <= ack;
        @(posedge CLOCK_50);
        key_valid     <= 1'b0;
        interrupt_ack <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    initial begin
        int          n;
        int          word;
        logic [63:0] data;
        logic [63:0] rdata;
        logic        err;
        logic [7:0]  code;
        cpu_req       <= '0;
        key_valid     <= 1'b0;
        key_ascii     <= 8'd0;
        interrupt_ack <= 1'b0;
        done_prev     = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        seed          = 32'h0a8f_145e;

        n = 0;
        while (KEY0 !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (KEY0 !== 1'b1) begin
            timeout_count++;
            $display("Timeout: reset was never released");
        end
        @(negedge CLOCK_50);
        assert (!done_any && !cpu_rsp.error && interrupt_vector == 4'd0) else begin
            report_error("outputs not idle after reset");
        end

        // Random words, banks taken in turn
        write_ram(ram_addr(0, 0), {$random(seed), $random(seed)});
        for (int i = 0; i < RANDOM_OPS; i++) begin
            word = $unsigned($random(seed)) % `BANK_WORDS;
            write_ram(ram_addr(i % `N_BANKS, word), {$random(seed), $random(seed)});
        end
        check_all_ram();

        // Below RAM, past RAM, past the key block, above 4 GB
        access_unmapped(64'(`RAM_BASE) - 64'd4);
        access_unmapped(64'(`RAM_BASE) + 64'(`RAM_SIZE));
        access_unmapped(64'(`KEY_BASE) + 64'd8);
        access_unmapped(64'h1_0000_2000);
        check_all_ram();

        // Key event and register reads
        code = 8'($random(seed));
        strobe_key_inputs(1'b1, code, 1'b0);
        check_value(64'(interrupt_vector), 64'd1, "interrupt_vector after key");
        read_expect(64'(`KEY_BASE), {56'd0, code});
        read_expect(64'(`KEY_BASE) + 64'd4, 64'd1);
        // Key block ignores writes
        run_access(1'b1, 64'(`KEY_BASE), {$random(seed), $random(seed)}, rdata, err);
        assert (!err) else report_error("error on key block write");
        read_expect(64'(`KEY_BASE), {56'd0, code});
        strobe_key_inputs(1'b0, 8'd0, 1'b1);
        check_value(64'(interrupt_vector), 64'd0, "interrupt_vector after ack");
        read_expect(64'(`KEY_BASE) + 64'd4, 64'd0);
        // Ack beats a key in the same cycle
        strobe_key_inputs(1'b1, 8'($random(seed)), 1'b0);
        strobe_key_inputs(1'b1, 8'($random(seed)), 1'b1);
        check_value(64'(interrupt_vector), 64'd0, "interrupt_vector after ack with key");

        // Last word of a bank and first word of the next
        for (int k = 0; k < `N_BANKS - 1; k++) begin
            data = {$random(seed), $random(seed)};
            write_ram(ram_addr(k, `BANK_WORDS - 1), data);
            write_ram(ram_addr(k + 1, 0), ~data);
            read_expect(ram_addr(k, `BANK_WORDS - 1), {32'd0, data[31:0]});
            read_expect(ram_addr(k + 1, 0), {32'd0, ~data[31:0]});
        end
        check_all_ram();

        $display("Checks done: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog/bus_bridge.sv
`timescale 1ns/10ps
`include "soc_config.svh"

module bus_bridge import soc_pkg::*; (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  cpu_req_t            cpu_req,
    output apb_req_t            apb_req,
    output logic [`N_SLOTS-1:0] psel,
    input  logic                pready
);

    // Bank index and word index widths
    localparam int BANK_BITS = $clog2(`N_BANKS);
    localparam int WORD_BITS = $clog2(`BANK_WORDS);

    bridge_state_e state;

    // Latched request
    logic [63:0] addr_q;
    logic [31:0] wdata_q;
    logic        write_q;

    // Decoder results
    logic [63:0]          ram_off;
    logic [63:0]          key_off;
    logic                 ram_hit;
    logic                 key_hit;
    logic [BANK_BITS-1:0] bank_idx;
    logic [`N_SLOTS-1:0]  sel_dec;
    logic [31:0]          slot_addr;

    logic req_seen;

    // New request only counts while idle
    assign req_seen = cpu_req.read_enable || cpu_req.write_enable;

    // Offsets into each region
    assign ram_off = addr_q - 64'(`RAM_BASE);
    assign key_off = addr_q - 64'(`KEY_BASE);

    // Region hits, lower bound checked first so the offset cannot wrap
    assign ram_hit = (addr_q >= 64'(`RAM_BASE)) && (ram_off < 64'(`RAM_SIZE));
    assign key_hit = (addr_q >= 64'(`KEY_BASE)) && (key_off < 64'(`KEY_SIZE));

    // Bank k owns the k-th contiguous slice
    assign bank_idx = ram_off[WORD_BITS+2 +: BANK_BITS];

    // One-hot slot select and slot-relative word address
    always_comb begin
        sel_dec   = '0;
        slot_addr = '0;
        if (ram_hit) begin
            sel_dec[bank_idx] = 1'b1;
            slot_addr         = 32'(ram_off[WORD_BITS+1:2]);
        end else if (key_hit) begin
            sel_dec[`KEY_SLOT] = 1'b1;
            // Word 0 is the code, word 1 the status
            slot_addr          = {31'd0, key_off[2]};
        end
    end

    // Control state
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state   <= st_idle;
            write_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_seen) begin
                        write_q <= cpu_req.write_enable;
                        state   <= st_setup;
                    end
                end
                st_setup: begin
                    state <= st_access;
                end
                st_access: begin
                    // Slaves have no wait states but the handshake stays
                    if (pready) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    // Enables are ignored here while the CPU sees done
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Request payload
    always_ff @(posedge CLOCK_50) begin
        if (state == st_idle && req_seen) begin
            addr_q  <= cpu_req.address;
            // RAM is 32 bits wide so the upper half is dropped
            wdata_q <= cpu_req.write_data[31:0];
        end
    end

    // APB drive
    // Unmapped addresses still run setup and access with no psel
    always_comb begin
        apb_req.paddr   = slot_addr;
        apb_req.pwrite  = write_q;
        apb_req.penable = (state == st_access);
        apb_req.pwdata  = wdata_q;
        if (state == st_setup || state == st_access) begin
            psel = sel_dec;
        end else begin
            psel = '0;
        end
    end

endmodule

//--- verilog/cpu_on_board.sv
`timescale 1ns/10ps
`include "soc_config.svh"

module cpu_on_board import soc_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  cpu_req_t   cpu_req,
    output cpu_rsp_t   cpu_rsp,
    input  logic       key_valid,
    input  logic [7:0] key_ascii,
    input  logic       interrupt_ack,
    output logic [3:0] interrupt_vector
);

    // Shared APB request and per-slot selects
    apb_req_t            apb_req;
    logic [`N_SLOTS-1:0] psel;
    logic                pready;

    // One response per slot, banks first
    apb_rsp_t slot_rsp [`N_SLOTS];

    // CPU request into APB
    bus_bridge u_bridge (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .cpu_req  (cpu_req),
        .apb_req  (apb_req),
        .psel     (psel),
        .pready   (pready)
    );

    // RAM bank array
    genvar k;
    generate
        for (k = 0; k < `N_BANKS; k++) begin : g_bank
            ram_bank u_bank (
                .CLOCK_50 (CLOCK_50),
                .apb_req  (apb_req),
                .psel     (psel[k]),
                .apb_rsp  (slot_rsp[k])
            );
        end
    endgenerate

    // Keyboard and interrupt registers in the last slot
    key_intc u_key (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .apb_req          (apb_req),
        .psel             (psel[`KEY_SLOT]),
        .apb_rsp          (slot_rsp[`KEY_SLOT]),
        .key_valid        (key_valid),
        .key_ascii        (key_ascii),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector)
    );

    // Responses back to the CPU
    resp_merge u_merge (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .apb_req  (apb_req),
        .psel     (psel),
        .slot_rsp (slot_rsp),
        .pready   (pready),
        .cpu_rsp  (cpu_rsp)
    );

endmodule

//--- verilog/key_intc.sv
`timescale 1ns/10ps
`include "soc_config.svh"

module key_intc import soc_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  apb_req_t   apb_req,
    input  logic       psel,
    output apb_rsp_t   apb_rsp,
    input  logic       key_valid,
    input  logic [7:0] key_ascii,
    input  logic       interrupt_ack,
    output logic [3:0] interrupt_vector
);

    // Last decoded key
    logic [7:0] key_code;

    // Interrupt still waiting for an ack
    logic pending;

    // Register select from the bridge word offset
    logic status_sel;

    logic read_sel;

    assign pending    = (interrupt_vector != 4'd0);
    assign status_sel = apb_req.paddr[0];
    assign read_sel   = psel && !apb_req.pwrite;

    // Key code capture
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_code <= 8'd0;
        end else if (key_valid) begin
            key_code <= key_ascii;
        end
    end

    // Interrupt controller
    // Vector 1 is the keyboard line
    // One shot, cleared by the CPU ack
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= 4'd0;
        end else begin
            if (interrupt_ack) begin
                // Ack wins over a new key in the same cycle
                interrupt_vector <= 4'd0;
            end else if (key_valid) begin
                interrupt_vector <= 4'd1;
            end
        end
    end

    // APB read side
    // Writes complete normally but change nothing
    always_comb begin
        apb_rsp.pready = psel;
        apb_rsp.prdata = '0;
        if (read_sel) begin
            if (status_sel) begin
                // Offset 4 is the pending bit
                apb_rsp.prdata = {31'd0, pending};
            end else begin
                // Offset 0 is the code, zero-extended
                apb_rsp.prdata = {24'd0, key_code};
            end
        end
    end

endmodule

//--- verilog/ram_bank.sv
`timescale 1ns/10ps
`include "soc_config.svh"

module ram_bank import soc_pkg::*; (
    input  logic     CLOCK_50,
    input  apb_req_t apb_req,
    input  logic     psel,
    output apb_rsp_t apb_rsp
);

    localparam int WORD_BITS = $clog2(`BANK_WORDS);

    // Block RAM storage
    logic [31:0] mem [`BANK_WORDS];

    logic [WORD_BITS-1:0] word_idx;
    logic [31:0]          rdata_q;
    logic                 setup_phase;
    logic                 write_phase;

    // Bank-relative word address from the bridge
    assign word_idx = apb_req.paddr[WORD_BITS-1:0];

    // Setup cycle starts the registered read
    assign setup_phase = psel && !apb_req.penable;

    // Write lands in the access cycle
    assign write_phase = psel && apb_req.penable && apb_req.pwrite;

    always_ff @(posedge CLOCK_50) begin
        if (write_phase) begin
            mem[word_idx] <= apb_req.pwdata;
        end
    end

    // Read port
    // Data is ready by the access cycle
    always_ff @(posedge CLOCK_50) begin
        if (setup_phase) begin
            rdata_q <= mem[word_idx];
        end
    end

    // Response
    // No wait states, ready whenever selected
    always_comb begin
        apb_rsp.pready = psel;
        if (psel && !apb_req.pwrite) begin
            apb_rsp.prdata = rdata_q;
        end else begin
            // Quiet bus when not ours so the merger can OR
            apb_rsp.prdata = '0;
        end
    end

endmodule

//--- verilog/resp_merge.sv
`timescale 1ns/10ps
`include "soc_config.svh"

module resp_merge import soc_pkg::*; (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  apb_req_t            apb_req,
    input  logic [`N_SLOTS-1:0] psel,
    input  apb_rsp_t            slot_rsp [`N_SLOTS],
    output logic                pready,
    output cpu_rsp_t            cpu_rsp
);

    logic [31:0] merged_rdata;
    logic        merged_ready;
    logic        no_slot;
    logic        xfer;

    // Registered CPU response
    logic [63:0] read_data_q;
    logic        read_done_q;
    logic        write_done_q;
    logic        error_q;

    // OR of the selected slots
    always_comb begin
        merged_rdata = '0;
        merged_ready = 1'b0;
        for (int i = 0; i < `N_SLOTS; i++) begin
            if (psel[i]) begin
                merged_rdata = merged_rdata | slot_rsp[i].prdata;
                merged_ready = merged_ready | slot_rsp[i].pready;
            end
        end
    end

    // Unmapped access finishes at once with an error
    assign no_slot = (psel == '0);
    assign pready  = merged_ready || no_slot;

    // End of an APB transfer
    assign xfer = apb_req.penable && pready;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done_q  <= 1'b0;
            write_done_q <= 1'b0;
            error_q      <= 1'b0;
        end else begin
            // Single-cycle pulses
            read_done_q  <= xfer && !apb_req.pwrite;
            write_done_q <= xfer && apb_req.pwrite;
            error_q      <= xfer && no_slot;
        end
    end

    // Read data is zero for an unmapped read since nothing drives it
    always_ff @(posedge CLOCK_50) begin
        if (xfer && !apb_req.pwrite) begin
            read_data_q <= {32'd0, merged_rdata};
        end
    end

    always_comb begin
        cpu_rsp.read_data  = read_data_q;
        cpu_rsp.read_done  = read_done_q;
        cpu_rsp.write_done = write_done_q;
        cpu_rsp.error      = error_q;
    end

endmodule

//--- verilog/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Address map of the bus side
// All addresses are CPU byte addresses

// First RAM bank starts here
`define RAM_BASE 32'h0000_2000

// Number of identical RAM banks
`define N_BANKS 4

// 32-bit words held by one bank
`define BANK_WORDS 256

// Bytes per bank and for the whole RAM region
`define BANK_BYTES (`BANK_WORDS * 4)
`define RAM_SIZE (`N_BANKS * `BANK_BYTES)

// Key block with two word registers
// Offset 0 holds the key code, offset 4 the interrupt status
`define KEY_BASE 32'h0001_0000
`define KEY_SIZE 8

// APB slots are the banks plus the key block
// Key block sits in the last slot
`define N_SLOTS (`N_BANKS + 1)
`define KEY_SLOT `N_BANKS

`endif

//--- verilog/soc_pkg.sv
package soc_pkg;

    // Request from the CPU bus port
    // Exactly one enable is high while a request is pending
    typedef struct packed {
        logic [63:0] address;
        logic [63:0] write_data;
        logic        read_enable;
        logic        write_enable;
    } cpu_req_t;

    // Response back to the CPU bus port
    // Done flags are one-cycle pulses
    typedef struct packed {
        logic [63:0] read_data;
        logic        read_done;
        logic        write_done;
        logic        error;
    } cpu_rsp_t;

    // APB request shared by every slot
    // Slot selection travels separately as a one-hot psel vector
    typedef struct packed {
        logic [31:0] paddr;
        logic        pwrite;
        logic        penable;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB response from one slot
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apb_rsp_t;

    // Bridge sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access,
        st_done
    } bridge_state_e;

endpackage

//--- vlog.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/bus_bridge.sv
verilog/ram_bank.sv
verilog/key_intc.sv
verilog/resp_merge.sv
verilog/cpu_on_board.sv
test/tb_clock.sv
test/tb_cpu_on_board.sv
